/* rtl/soc_macros.svh */
// Bus widths, region map and pad scan timing, included wherever a width or base address is needed
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Wishbone widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// Region base addresses
`define PAD_BASE 32'h0200_0200
`define TICK_BASE 32'h0200_0300
`define CONF_BASE 32'h0200_0400

// Region sizes as byte address bits
`define PAD_SPAN_BITS 2
`define TICK_SPAN_BITS 8
`define CONF_SPAN_BITS 10

// Config memory depth in words
`define CONF_DEPTH 256

// One pad tick is 2**PAD_DIV_BITS clocks
`define PAD_DIV_BITS 9

`endif

/* rtl/soc_bus_pkg.sv */
// Bus types shared by the decoder, the targets and the response stage
`include "soc_macros.svh"

package soc_bus_pkg;

	// Region selected by the decoder
	typedef enum logic [1:0] {
		tgt_none,
		tgt_pad,
		tgt_tick,
		tgt_conf
	} bus_target_e;

	// One decoded request, addr holds the word address
	typedef struct packed {
		logic [`SOC_ADDR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] wdata;
		logic [`SOC_SEL_W-1:0] sel;
		logic we;
	} bus_req_t;

endpackage

/* rtl/pad_pkg.sv */
// Types for the serial game pad scanner
package pad_pkg;

	// Scan sequence, one state per group of pad ticks
	typedef enum logic [1:0] {
		pad_idle,
		pad_latch,
		pad_shift,
		pad_done
	} pad_state_e;

	// Button bits of one pad, 1 means pressed
	typedef logic [7:0] pad_byte_t;

endpackage

/* rtl/periph_bus_if.sv */
// Decoded request from the decoder to the targets, plus their read data for the response stage
`timescale 1ns/10ps
`include "soc_macros.svh"

interface periph_bus_if import soc_bus_pkg::*; ();
	logic valid;
	bus_target_e target;
	bus_req_t req;
	logic [`SOC_DATA_W-1:0] conf_rdata;
	logic [`SOC_DATA_W-1:0] pad_rdata;

	modport decoder (output valid, output target, output req);

	modport conf (input valid, input target, input req, output conf_rdata);

	modport pad (output pad_rdata);

	modport response (
		input valid,
		input target,
		input req,
		input conf_rdata,
		input pad_rdata
	);
endinterface

/* rtl/addr_decode.sv */
// Decode stage that takes one Wishbone request at a time and hands it to the targets
`timescale 1ns/10ps
`include "soc_macros.svh"

module addr_decode import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`SOC_ADDR_W-1:0] wb_adr,
	input logic [`SOC_DATA_W-1:0] wb_dat_w,
	input logic [`SOC_SEL_W-1:0] wb_sel,
	input logic done,
	periph_bus_if.decoder bus
);
	logic busy;
	logic answered;
	logic take;
	bus_target_e target_nxt;

	assign take = !busy && wb_cyc && wb_stb;

	always_comb begin
		if ((wb_adr >> `PAD_SPAN_BITS) == (`PAD_BASE >> `PAD_SPAN_BITS))
			target_nxt = tgt_pad;
		else if ((wb_adr >> `TICK_SPAN_BITS) == (`TICK_BASE >> `TICK_SPAN_BITS))
			target_nxt = tgt_tick;
		else if ((wb_adr >> `CONF_SPAN_BITS) == (`CONF_BASE >> `CONF_SPAN_BITS))
			target_nxt = tgt_conf;
		else
			target_nxt = tgt_none;
	end

	// Stay busy until answered and the master has let go of stb
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			busy <= 1'b0;
			answered <= 1'b0;
			bus.valid <= 1'b0;
		end else begin
			bus.valid <= take;
			if (take) begin
				busy <= 1'b1;
			end else if (busy && (done || answered)) begin
				answered <= wb_stb;
				if (!wb_stb)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (take) begin
			bus.target <= target_nxt;
			bus.req <= '{
				addr: {2'b00, wb_adr[`SOC_ADDR_W-1:2]},
				wdata: wb_dat_w,
				sel: wb_sel,
				we: wb_we
			};
		end
	end
endmodule

/* rtl/config_mem.sv */
// Configuration memory target with byte-select writes and a registered read word
`timescale 1ns/10ps
`include "soc_macros.svh"

module config_mem import soc_bus_pkg::*; (
	input logic clk_50mhz,
	periph_bus_if.conf bus
);
	localparam int AW = $clog2(`CONF_DEPTH);

	logic [`SOC_DATA_W-1:0] mem [`CONF_DEPTH];
	logic [AW-1:0] word_addr;

	// Base is region aligned, so the low bits are the offset
	assign word_addr = bus.req.addr[AW-1:0];

	always_ff @(posedge clk_50mhz) begin
		if (bus.valid) begin
			if (bus.target == tgt_conf && bus.req.we) begin
				for (int i = 0; i < `SOC_SEL_W; i++) begin
					if (bus.req.sel[i])
						mem[word_addr][i*8 +: 8] <= bus.req.wdata[i*8 +: 8];
				end
			end
			// Old word on a write, response ignores it then
			bus.conf_rdata <= mem[word_addr];
		end
	end
endmodule

/* rtl/pad_reader.sv */
// Continuous scanner for two serial game pads, holds the last complete button bytes
`timescale 1ns/10ps
`include "soc_macros.svh"

module pad_reader import pad_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,
	input logic c1data,
	input logic c2data,
	output logic c1clock,
	output logic c1latch,
	output logic c2clock,
	output logic c2latch,
	periph_bus_if.pad bus
);
	logic [`PAD_DIV_BITS-1:0] div;
	logic tick;
	pad_state_e state;
	logic phase;
	logic [2:0] bit_cnt;
	pad_byte_t sr0;
	pad_byte_t sr1;
	pad_byte_t pad0;
	pad_byte_t pad1;

	assign tick = &div;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			div <= '0;
		else
			div <= div + 1'b1;
	end

	// phase 0 is the low half of a bit, 1 the high half
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state <= pad_idle;
			phase <= 1'b0;
			bit_cnt <= 3'd0;
			pad0 <= '0;
			pad1 <= '0;
		end else if (tick) begin
			case (state)
				pad_idle: state <= pad_latch;
				pad_latch: begin
					state <= pad_shift;
					phase <= 1'b0;
					bit_cnt <= 3'd0;
				end
				pad_shift: begin
					phase <= !phase;
					if (phase) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= pad_done;
					end
				end
				pad_done: begin
					pad0 <= sr0;
					pad1 <= sr1;
					state <= pad_idle;
				end
			endcase
		end
	end

	// Sample at the end of the low half, pads are active low
	always_ff @(posedge clk_50mhz) begin
		if (tick && state == pad_shift && !phase) begin
			sr0 <= {~c1data, sr0[7:1]};
			sr1 <= {~c2data, sr1[7:1]};
		end
	end

	assign c1latch = state == pad_latch;
	assign c2latch = state == pad_latch;
	assign c1clock = state == pad_shift && phase;
	assign c2clock = state == pad_shift && phase;

	assign bus.pad_rdata = {{(`SOC_DATA_W - 16){1'b0}}, pad1, pad0};
endmodule

/* rtl/bus_response.sv */
// Result stage that picks the read data, keeps the tick counter and answers with ack or err
`timescale 1ns/10ps
`include "soc_macros.svh"

module bus_response import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,
	periph_bus_if.response bus,
	output logic [`SOC_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic wb_err,
	output logic done
);
	logic valid_q;
	bus_target_e target_q;
	logic we_q;
	logic [`SOC_DATA_W-1:0] tick_cnt;
	logic [`SOC_DATA_W-1:0] hold_q;
	logic ok;

	// System tick, counts every clock since reset
	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			valid_q <= 1'b0;
		else
			valid_q <= bus.valid;
	end

	always_ff @(posedge clk_50mhz) begin
		if (bus.valid) begin
			target_q <= bus.target;
			we_q <= bus.req.we;
			hold_q <= (bus.target == tgt_tick) ? tick_cnt : bus.pad_rdata;
		end
	end

	always_comb begin
		case (target_q)
			tgt_conf: wb_dat_r = bus.conf_rdata;
			tgt_tick, tgt_pad: wb_dat_r = hold_q;
			default: wb_dat_r = '0;
		endcase
	end

	// Tick and pad are read only
	assign ok = target_q == tgt_conf || (target_q != tgt_none && !we_q);
	assign wb_ack = valid_q && ok;
	assign wb_err = valid_q && !ok;
	assign done = valid_q;
endmodule

/* rtl/periph_top.sv */
// Peripheral top level with a Wishbone classic slave port and two serial pad connectors
`timescale 1ns/10ps
`include "soc_macros.svh"

module periph_top (
	input logic clk_50mhz,
	input logic resetn,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`SOC_ADDR_W-1:0] wb_adr,
	input logic [`SOC_DATA_W-1:0] wb_dat_w,
	input logic [`SOC_SEL_W-1:0] wb_sel,
	output logic [`SOC_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic wb_err,
	output logic c1clock,
	output logic c1latch,
	input logic c1data,
	output logic c2clock,
	output logic c2latch,
	input logic c2data
);
	logic done;

	periph_bus_if bus ();

	addr_decode u_decode (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.done(done),
		.bus(bus.decoder)
	);

	config_mem u_conf (
		.clk_50mhz(clk_50mhz),
		.bus(bus.conf)
	);

	pad_reader u_pad (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.c1data(c1data),
		.c2data(c2data),
		.c1clock(c1clock),
		.c1latch(c1latch),
		.c2clock(c2clock),
		.c2latch(c2latch),
		.bus(bus.pad)
	);

	bus_response u_resp (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus(bus.response),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wb_err(wb_err),
		.done(done)
	);
endmodule

/* sim/tb_wb_tasks.svh */
// Wishbone master tasks and the pad shift step, included inside the testbench module body
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// Cycles allowed for one access before it counts as hung
localparam int ACCESS_LIMIT = 16;

// Starts right after a falling edge and returns after the stb gap cycle
task automatic wb_access(
	input logic we,
	input logic [`SOC_ADDR_W-1:0] adr,
	input logic [`SOC_DATA_W-1:0] wdata,
	input logic [`SOC_SEL_W-1:0] sel,
	output logic [`SOC_DATA_W-1:0] rdata,
	output logic ack,
	output logic err,
	output int cycles
);
	ack = 1'b0;
	err = 1'b0;
	rdata = '0;
	cycles = 0;
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = we;
	wb_adr = adr;
	wb_dat_w = wdata;
	wb_sel = sel;
	while (!ack && !err && cycles < ACCESS_LIMIT) begin
		@(negedge clk_50mhz);
		cycles++;
		ack = wb_ack;
		err = wb_err;
		rdata = wb_dat_r;
	end
	assert (ack || err)
	else begin
		$display("Access to 0x%08h got neither ack nor err in %0d cycles", adr, ACCESS_LIMIT);
		fail_count++;
		test_fails++;
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
	// Master keeps stb low for one cycle
	@(negedge clk_50mhz);
endtask

task automatic write_word(
	input logic [`SOC_ADDR_W-1:0] adr,
	input logic [`SOC_DATA_W-1:0] data,
	input logic [`SOC_SEL_W-1:0] sel,
	output logic ack,
	output logic err,
	output int cycles
);
	logic [`SOC_DATA_W-1:0] ignored;
	wb_access(1'b1, adr, data, sel, ignored, ack, err, cycles);
endtask

task automatic read_word(
	input logic [`SOC_ADDR_W-1:0] adr,
	output logic [`SOC_DATA_W-1:0] data,
	output logic ack,
	output logic err,
	output int cycles
);
	wb_access(1'b0, adr, '0, '1, data, ack, err, cycles);
endtask

// One step of the serial pad register, refilled with released bits
function automatic logic [7:0] pad_shift(input logic [7:0] sr);
	return {1'b1, sr[7:1]};
endfunction

`endif

/* sim/tb_periph_top.sv */
// Testbench for the peripheral top level, runs Wishbone accesses against two serial pad models
`timescale 1ns/10ps
`include "soc_macros.svh"

module tb_periph_top;
	localparam int SCAN_CYCLES = 19 * (1 << `PAD_DIV_BITS);
	localparam int TIMEOUT_CYCLES = 30 * SCAN_CYCLES + 200 * 8;

	logic clk_50mhz;
	logic resetn;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`SOC_ADDR_W-1:0] wb_adr;
	logic [`SOC_DATA_W-1:0] wb_dat_w;
	logic [`SOC_SEL_W-1:0] wb_sel;
	logic [`SOC_DATA_W-1:0] wb_dat_r;
	logic wb_ack;
	logic wb_err;
	logic c1clock;
	logic c1latch;
	logic c2clock;
	logic c2latch;
	logic [7:0] pad0_raw = 8'hff;
	logic [7:0] pad1_raw = 8'hff;
	logic [7:0] pad0_sr = 8'hff;
	logic [7:0] pad1_sr = 8'hff;
	wire c1data = pad0_sr[0];
	wire c2data = pad1_sr[0];
	int fail_count = 0;
	int check_count = 0;
	int test_fails = 0;
	int test_checks = 0;
	logic [`SOC_DATA_W-1:0] exp_mem [`CONF_DEPTH];

	periph_top uut (.*);

	`include "tb_wb_tasks.svh"

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		test_checks++;
		assert (act === exp)
		else begin
			$display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
			fail_count++;
			test_fails++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, test_checks, test_fails);
		test_checks = 0;
		test_fails = 0;
	endtask

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	// Pad models reload on a rising latch and shift on a rising clock
	always @(posedge c1latch or posedge c1clock)
		pad0_sr <= c1latch ? pad0_raw : pad_shift(pad0_sr);
	always @(posedge c2latch or posedge c2clock)
		pad1_sr <= c2latch ? pad1_raw : pad_shift(pad1_sr);

	initial begin
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_50mhz);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		int unsigned idx;
		int unsigned n;
		int unsigned addrs[$];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t1;
		logic [31:0] rd;
		logic [31:0] merged;
		logic [3:0] mask;
		logic ack;
		logic err;
		int cycles;
		void'($urandom(32'ha79c_d73e));
		resetn = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		repeat (3) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		resetn = 1'b1;
		@(negedge clk_50mhz);

		for (int i = 0; i < 16; i++) begin
			idx = $urandom_range(`CONF_DEPTH - 1, 0);
			a = $urandom;
			exp_mem[idx] = a;
			addrs.push_back(idx);
			write_word(`CONF_BASE + (idx << 2), a, 4'hf, ack, err, cycles);
			check_value("conf_write_ack", 1, ack);
		end
		foreach (addrs[i]) begin
			read_word(`CONF_BASE + (addrs[i] << 2), rd, ack, err, cycles);
			check_value("conf_readback", exp_mem[addrs[i]], rd);
		end
		end_test("config_memory");

		for (int k = 0; k < 4; k++) begin
			idx = $urandom_range(`CONF_DEPTH - 1, 0);
			a = $urandom;
			b = $urandom;
			mask = 4'($urandom);
			for (int i = 0; i < 4; i++)
				merged[i*8 +: 8] = mask[i] ? b[i*8 +: 8] : a[i*8 +: 8];
			write_word(`CONF_BASE + (idx << 2), a, 4'hf, ack, err, cycles);
			write_word(`CONF_BASE + (idx << 2), b, mask, ack, err, cycles);
			read_word(`CONF_BASE + (idx << 2), rd, ack, err, cycles);
			check_value("byte_select", merged, rd);
		end
		end_test("byte_select");

		write_word(`CONF_BASE, 32'h1234_5678, 4'hf, ack, err, cycles);
		check_value("write_latency", 2, cycles);
		read_word(`TICK_BASE, rd, ack, err, cycles);
		check_value("read_latency", 2, cycles);
		check_value("tick_read_ack_err", 2'b10, {ack, err});
		read_word(32'h0000_1000, rd, ack, err, cycles);
		check_value("unmapped_read_ack_err", 2'b01, {ack, err});
		read_word(`PAD_BASE + 4, rd, ack, err, cycles);
		check_value("past_pad_ack_err", 2'b01, {ack, err});
		write_word(`TICK_BASE, 32'hffff_ffff, 4'hf, ack, err, cycles);
		check_value("tick_write_ack_err", 2'b01, {ack, err});
		write_word(`PAD_BASE, 32'hffff_ffff, 4'hf, ack, err, cycles);
		check_value("pad_write_ack_err", 2'b01, {ack, err});
		end_test("timing_error");

		for (int k = 0; k < 3; k++) begin
			n = $urandom_range(20, 0);
			read_word(`TICK_BASE, t1, ack, err, cycles);
			repeat (n) @(negedge clk_50mhz);
			read_word(`TICK_BASE, rd, ack, err, cycles);
			check_value("tick_delta", n + 3, rd - t1);
		end
		end_test("tick_counter");

		for (int k = 0; k < 2; k++) begin
			pad0_raw = 8'($urandom);
			pad1_raw = 8'($urandom);
			repeat (2 * SCAN_CYCLES + (1 << `PAD_DIV_BITS)) @(negedge clk_50mhz);
			read_word(`PAD_BASE, rd, ack, err, cycles);
			check_value("pad_bytes", {16'h0000, ~pad1_raw, ~pad0_raw}, rd);
		end
		end_test("pads");

		$display("Summary: %0d checks, %0d errors", check_count, fail_count);
		if (fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end
endmodule

/* files.f */
+incdir+rtl
+incdir+sim
rtl/soc_bus_pkg.sv
rtl/pad_pkg.sv
rtl/periph_bus_if.sv
rtl/addr_decode.sv
rtl/config_mem.sv
rtl/pad_reader.sv
rtl/bus_response.sv
rtl/periph_top.sv
sim/tb_periph_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for a failure in the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	-f files.f --top-module tb_periph_top -o tb_periph_top > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build did not complete"; exit 1; }
./obj_dir/tb_periph_top > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited with an error status"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation log is clean"
exit 0
